//--- icache_sub.f
verilog/icache_pkg.sv
verilog/bram.sv
verilog/instruction_cache.sv
verilog/memory_read_port.sv
verilog/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

//--- verif/icache_tb.sv
// Testbench for the instruction fetch side: reset sweep, fills, eviction, flush, back-pressure.
// Runs a stimulus table in a loop against icache_top and a memory model.
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

	localparam int DEPTH_BITS = 4;
	localparam int CREDITS    = 4;
	localparam int N          = 23;	// table length.
	localparam int SWEEP      = (2**DEPTH_BITS) + 2;
	localparam int LIMIT      = N * 40 + 2 * SWEEP + 20;	// cycles before giving up.

	// ==============================
	// signals
	// ==============================
	logic                          CLK;
	logic                          RSTb;
	logic [icache_pkg::ADDR_W-1:0] fetch_address;
	logic [icache_pkg::LINE_W-1:0] fetch_line;
	logic                          fetch_miss;
	logic                          invalidate_cache;
	logic                          invalidation_done;
	logic                          mem_rd_req;
	logic [icache_pkg::ADDR_W-1:0] mem_address;
	logic                          mem_credit_return;
	logic                          mem_success;
	logic [icache_pkg::ADDR_W-1:0] mem_requested_address;
	logic [icache_pkg::DATA_W-1:0] mem_data;

	int errors = 0;
	int tests  = 0;
	int cycles = 0;
	int outstanding = 0;	// requests minus returned credits.
	bit pending [2**icache_pkg::ADDR_W];	// address requested and not yet answered.
	logic last_done = 1'b0;	// invalidation_done one cycle ago.

	// ==============================
	// stimulus table
	// ==============================
	// each step fetches and holds (F), touches for one cycle (T) or invalidates (I).
	// expected first look is 0 for a hit, 1 for a miss and 2 when either may show.
	string step_name [N] = '{"cold_a", "hit_a", "evict_by_b", "refetch_a", "hit_a_again",
		"cold_c", "cold_d", "flush", "flushed_d", "flushed_a", "flushed_c",
		"touch_e", "touch_f", "touch_g", "touch_h", "touch_i", "touch_j",
		"fetch_e", "fetch_f", "fetch_g", "fetch_h", "fetch_i", "fetch_j"};
	byte step_op [N] = '{"F", "F", "F", "F", "F", "F", "F", "I", "F", "F", "F",
		"T", "T", "T", "T", "T", "T", "F", "F", "F", "F", "F", "F"};
	logic [14:0] step_addr [N] = '{15'h0102, 15'h0102, 15'h2202, 15'h0102, 15'h0102,
		15'h0044, 15'h1136, 15'h0000, 15'h1136, 15'h0102, 15'h0044,
		15'h0a08, 15'h0b0a, 15'h0c0c, 15'h0d0e, 15'h0e10, 15'h0f12,
		15'h0a08, 15'h0b0a, 15'h0c0c, 15'h0d0e, 15'h0e10, 15'h0f12};	// a and b share index 1.
	int step_exp [N] = '{1, 0, 1, 1, 0, 1, 1, 2, 1, 1, 1, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2};

	// ==============================
	// dut and memory
	// ==============================
	icache_top #(
		.CACHE_DEPTH_BITS(DEPTH_BITS),
		.MAX_CREDITS     (CREDITS)
	) i_dut (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.fetch_address        (fetch_address),
		.fetch_line           (fetch_line),
		.fetch_miss           (fetch_miss),
		.invalidate_cache     (invalidate_cache),
		.invalidation_done    (invalidation_done),
		.mem_rd_req           (mem_rd_req),
		.mem_address          (mem_address),
		.mem_credit_return    (mem_credit_return),
		.mem_success          (mem_success),
		.mem_requested_address(mem_requested_address),
		.mem_data             (mem_data)
	);

	icache_mem_model i_mem (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.mem_rd_req           (mem_rd_req),
		.mem_address          (mem_address),
		.mem_credit_return    (mem_credit_return),
		.mem_success          (mem_success),
		.mem_requested_address(mem_requested_address),
		.mem_data             (mem_data)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;	// 10 ns period.
	end

	// tag, cleared invalid bit, then the memory word.
	function automatic logic [31:0] line_for(input logic [14:0] a);
		return {a, 1'b0, 1'b1, ~a};
	endfunction

	// ==============================
	// bus monitor and timeout
	// ==============================
	always @(posedge CLK) begin
		cycles++;
		if (RSTb) begin
			if (mem_rd_req) begin
				assert (!pending[mem_address]) else begin
					$display("address %h requested again while still pending", mem_address);
					errors++;
				end
				pending[mem_address] = 1'b1;
			end
			if (mem_success) begin
				pending[mem_requested_address] = 1'b0;
			end
			outstanding = outstanding + int'(mem_rd_req) - int'(mem_credit_return);
			assert (outstanding <= CREDITS) else begin
				$display("more than %0d requests outstanding", CREDITS);
				errors++;
			end
			assert (!(invalidation_done && last_done)) else begin
				$display("invalidation_done stayed high for more than one cycle");
				errors++;
			end
		end
		last_done = invalidation_done;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles", LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// ==============================
	// main sequence
	// ==============================
	initial begin : run
		int cnt;
		int err_before;
		RSTb             = 1'b0;
		fetch_address    = '0;
		invalidate_cache = 1'b0;
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;

		// no request may appear before the reset sweep ends.
		cnt = 0;
		do begin
			@(posedge CLK);
			cnt++;
			assert (!mem_rd_req) else begin
				$display("mem_rd_req raised during the reset sweep");
				errors++;
			end
		end while (!invalidation_done);
		tests++;
		assert (cnt == SWEEP) else begin
			$display("error reset_sweep expected %0d actual %0d", SWEEP, cnt);
			errors++;
		end
		$display("test reset_sweep done after %0d cycles", cnt);

		for (int s = 0; s < N; s++) begin
			err_before = errors;
			tests++;
			@(posedge CLK);
			if (step_op[s] == "I") begin
				invalidate_cache <= 1'b1;
				@(posedge CLK);
				invalidate_cache <= 1'b0;
				cnt = 0;
				do begin
					@(posedge CLK);
					cnt++;
				end while (!invalidation_done);
				assert (cnt == SWEEP - 1) else begin
					$display("error %s expected %0d actual %0d", step_name[s], SWEEP - 1, cnt);
					errors++;
				end
			end else if (step_op[s] == "T") begin
				fetch_address <= step_addr[s];	// the next step moves on after one cycle.
			end else begin
				fetch_address <= step_addr[s];
				repeat (2) @(posedge CLK);	// registered lookup.
				if (step_exp[s] != 2) begin
					assert (fetch_miss == step_exp[s][0]) else begin
						$display("error %s expected miss %0d actual %0d", step_name[s],
							step_exp[s], fetch_miss);
						errors++;
					end
				end
				while (fetch_miss) @(posedge CLK);
				assert (fetch_line == line_for(step_addr[s])) else begin
					$display("error %s expected %h actual %h", step_name[s],
						line_for(step_addr[s]), fetch_line);
					errors++;
				end
			end
			$display("test %s %s", step_name[s], (errors == err_before) ? "ok" : "failed");
		end

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/icache_mem_model.sv
// Memory arbiter model for the instruction fetch testbench.
// Queues read requests, answers each after 2 to 6 cycles and returns a credit with it.
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          mem_rd_req,
	input  logic [icache_pkg::ADDR_W-1:0] mem_address,
	output logic                          mem_credit_return,
	output logic                          mem_success,
	output logic [icache_pkg::ADDR_W-1:0] mem_requested_address,
	output logic [icache_pkg::DATA_W-1:0] mem_data
);

	logic [31:0]                   rng;	// xorshift state.
	int unsigned                   cycle;	// local time in clocks.
	int unsigned                   due_q[$];	// answer time per queued request.
	logic [icache_pkg::ADDR_W-1:0] addr_q[$];	// queued request addresses.

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// top bit set, lower bits hold the inverted address.
	function automatic logic [icache_pkg::DATA_W-1:0] word_at(
		input logic [icache_pkg::ADDR_W-1:0] a
	);
		return {1'b1, ~a};
	endfunction

	initial begin
		mem_credit_return     = 1'b0;
		mem_success           = 1'b0;
		mem_requested_address = '0;
		mem_data              = '0;
	end

	always @(posedge CLK) begin : serve
		logic [icache_pkg::ADDR_W-1:0] a;
		if (!RSTb) begin
			rng               = 32'd27;	// fixed seed.
			cycle             <= 0;
			due_q.delete();
			addr_q.delete();
			mem_credit_return <= 1'b0;
			mem_success       <= 1'b0;
		end else begin
			cycle             <= cycle + 1;
			mem_credit_return <= 1'b0;
			mem_success       <= 1'b0;
			if (mem_rd_req) begin
				rng = xorshift32(rng);
				addr_q.push_back(mem_address);
				due_q.push_back(cycle + 2 + (rng % 5));	// 2 to 6 cycles.
			end
			// answers leave in request order, one per cycle.
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				a = addr_q.pop_front();
				void'(due_q.pop_front());
				mem_success           <= 1'b1;
				mem_credit_return     <= 1'b1;	// credit comes back with the data.
				mem_requested_address <= a;
				mem_data              <= word_at(a);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
// Top level of the instruction fetch side: the cache and the memory read port.
// Faces the CPU fetch pins on one side and the memory arbiter pins on the other.
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
	parameter int CACHE_DEPTH_BITS = 8,	// cache index bits.
	parameter int MAX_CREDITS      = 4	// outstanding memory requests.
) (
	input  logic                          CLK,
	input  logic                          RSTb,

	// ==============================
	// cpu pins
	// ==============================
	input  logic [icache_pkg::ADDR_W-1:0] fetch_address,
	output logic [icache_pkg::LINE_W-1:0] fetch_line,
	output logic                          fetch_miss,
	input  logic                          invalidate_cache,
	output logic                          invalidation_done,

	// ==============================
	// memory pins
	// ==============================
	output logic                          mem_rd_req,
	output logic [icache_pkg::ADDR_W-1:0] mem_address,
	input  logic                          mem_credit_return,
	input  logic                          mem_success,
	input  logic [icache_pkg::ADDR_W-1:0] mem_requested_address,
	input  logic [icache_pkg::DATA_W-1:0] mem_data
);

	logic                          miss_req;	// cache to read port.
	logic [icache_pkg::ADDR_W-1:0] miss_address;
	logic                          fill_valid;	// read port to cache.
	logic [icache_pkg::ADDR_W-1:0] fill_address;
	logic [icache_pkg::DATA_W-1:0] fill_data;

	instruction_cache #(
		.CACHE_DEPTH_BITS(CACHE_DEPTH_BITS)
	) i_cache (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.request_address  (fetch_address),
		.address_data     (fetch_line),
		.cache_miss       (fetch_miss),
		.invalidate_cache (invalidate_cache),
		.invalidation_done(invalidation_done),
		.miss_req         (miss_req),
		.miss_address     (miss_address),
		.fill_valid       (fill_valid),
		.fill_address     (fill_address),
		.fill_data        (fill_data)
	);

	memory_read_port #(
		.MAX_CREDITS(MAX_CREDITS)
	) i_read_port (
		.CLK                  (CLK),
		.RSTb                 (RSTb),
		.miss_req             (miss_req),
		.miss_address         (miss_address),
		.fill_valid           (fill_valid),
		.fill_address         (fill_address),
		.fill_data            (fill_data),
		.mem_rd_req           (mem_rd_req),
		.mem_address          (mem_address),
		.mem_credit_return    (mem_credit_return),
		.mem_success          (mem_success),
		.mem_requested_address(mem_requested_address),
		.mem_data             (mem_data)
	);

endmodule

`default_nettype wire

//--- verilog/memory_read_port.sv
// Turns cache misses into read requests toward the memory arbiter under credit flow control.
// Tracks pending addresses so each miss is requested once and passes responses on as fills.
`timescale 1ns/10ps
`default_nettype none

module memory_read_port #(
	parameter int MAX_CREDITS = 4	// requests the memory accepts at once.
) (
	input  logic                          CLK,
	input  logic                          RSTb,

	// cache side.
	input  logic                          miss_req,
	input  logic [icache_pkg::ADDR_W-1:0] miss_address,
	output logic                          fill_valid,
	output logic [icache_pkg::ADDR_W-1:0] fill_address,
	output logic [icache_pkg::DATA_W-1:0] fill_data,

	// memory side.
	output logic                          mem_rd_req,	// one request per high cycle.
	output logic [icache_pkg::ADDR_W-1:0] mem_address,
	input  logic                          mem_credit_return,	// one credit back per pulse.
	input  logic                          mem_success,	// response strobe.
	input  logic [icache_pkg::ADDR_W-1:0] mem_requested_address,
	input  logic [icache_pkg::DATA_W-1:0] mem_data
);

	localparam int CRED_W = $clog2(MAX_CREDITS + 1);

	// ==============================
	// declarations
	// ==============================
	logic [CRED_W-1:0]             credits;	// free credits.
	logic [MAX_CREDITS-1:0]        pend_valid;	// one bit per outstanding request.
	logic [icache_pkg::ADDR_W-1:0] pend_addr [MAX_CREDITS];	// address of each request.
	logic [MAX_CREDITS-1:0]        pend_hit;	// miss address already outstanding.
	logic [MAX_CREDITS-1:0]        resp_hit;	// entry matching the response.
	logic [MAX_CREDITS-1:0]        alloc;	// lowest free entry, one-hot.

	logic                          last_fill_valid;	// a fill was written at the last edge.
	logic [icache_pkg::ADDR_W-1:0] last_fill_address;
	logic                          recent_fill;	// lookup still shows the pre-fill line.
	logic                          issue;

	// ==============================
	// request decision
	// ==============================
	always_comb begin
		for (int i = 0; i < MAX_CREDITS; i++) begin
			pend_hit[i] = pend_valid[i] && (pend_addr[i] == miss_address);
			resp_hit[i] = pend_valid[i] && (pend_addr[i] == mem_requested_address);
		end
	end

	assign alloc = ~pend_valid & (pend_valid + 1'b1);	// lowest zero bit.

	// the line read at the fill edge is stale for one cycle, so skip that miss.
	assign recent_fill = last_fill_valid && (last_fill_address == miss_address);

	assign issue = miss_req && !(|pend_hit) && !recent_fill && (credits != '0) && (|alloc);

	// ==============================
	// control state
	// ==============================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			credits         <= CRED_W'(MAX_CREDITS);
			pend_valid      <= '0;
			mem_rd_req      <= 1'b0;
			last_fill_valid <= 1'b0;
		end else begin
			credits         <= credits - CRED_W'(issue) + CRED_W'(mem_credit_return);
			mem_rd_req      <= issue;	// registered, so the entry is pending when it shows.
			last_fill_valid <= mem_success;
			for (int i = 0; i < MAX_CREDITS; i++) begin
				if (mem_success && resp_hit[i]) begin
					pend_valid[i] <= 1'b0;	// response frees its entry.
				end
				if (issue && alloc[i]) begin
					pend_valid[i] <= 1'b1;
				end
			end
		end
	end

	// payload.
	always_ff @(posedge CLK) begin
		last_fill_address <= mem_requested_address;
		if (issue) begin
			mem_address <= miss_address;
			for (int i = 0; i < MAX_CREDITS; i++) begin
				if (alloc[i]) begin
					pend_addr[i] <= miss_address;
				end
			end
		end
	end

	// responses go to the cache untouched.
	assign fill_valid   = mem_success;
	assign fill_address = mem_requested_address;
	assign fill_data    = mem_data;

	// ==============================
	// checks
	// ==============================
	a_credit_max: assert property (@(posedge CLK) disable iff (!RSTb)
		credits <= CRED_W'(MAX_CREDITS))
		else $error("credit count above MAX_CREDITS");

	a_resp_pending: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_success |-> (|resp_hit))
		else $error("memory response for an address that is not pending");

endmodule

`default_nettype wire

//--- verilog/instruction_cache.sv
// Direct-mapped instruction cache in one block RAM, with tag check and fill write.
// Sweeps every line invalid after reset or on request, then serves lookups in execute.
`timescale 1ns/10ps
`default_nettype none

module instruction_cache #(
	parameter int CACHE_DEPTH_BITS = 8	// index bits, taken from address bits [CACHE_DEPTH_BITS:1].
) (
	input  logic                          CLK,
	input  logic                          RSTb,

	// cpu side.
	input  logic [icache_pkg::ADDR_W-1:0] request_address,	// new word address every cycle.
	output logic [icache_pkg::LINE_W-1:0] address_data,	// line word, one cycle later.
	output logic                          cache_miss,	// tag mismatch or invalid line.
	input  logic                          invalidate_cache,	// start a sweep from execute.
	output logic                          invalidation_done,	// one-cycle pulse after a sweep.

	// read port side.
	output logic                          miss_req,	// miss flag, only in execute.
	output logic [icache_pkg::ADDR_W-1:0] miss_address,	// registered lookup address.
	input  logic                          fill_valid,
	input  logic [icache_pkg::ADDR_W-1:0] fill_address,
	input  logic [icache_pkg::DATA_W-1:0] fill_data
);

	// ==============================
	// declarations
	// ==============================
	icache_pkg::cache_state_t state, state_next;

	logic [CACHE_DEPTH_BITS-1:0]   sweep_addr, sweep_addr_next;	// line being invalidated.
	logic [icache_pkg::ADDR_W-1:0] address_x;	// lookup address, aligned with ram output.
	logic [icache_pkg::LINE_W-1:0] line_out;	// raw line word from the ram.

	logic                          fill_wr;	// memory response accepted.
	logic                          sweep_wr;	// sweep write this cycle.
	logic                          bram_wr;
	logic [CACHE_DEPTH_BITS-1:0]   bram_wr_addr;
	logic [icache_pkg::LINE_W-1:0] bram_wr_data;

	logic                          tag_match;
	logic                          line_valid;
	logic                          in_execute;

	// ==============================
	// write side
	// ==============================
	assign in_execute = (state == icache_pkg::st_execute);
	assign fill_wr    = fill_valid && in_execute;	// responses outside execute are dropped.
	assign sweep_wr   = (state == icache_pkg::st_invalidate);
	assign bram_wr    = fill_wr || sweep_wr;

	assign bram_wr_addr = sweep_wr ? sweep_addr : fill_address[CACHE_DEPTH_BITS:1];

	// sweep writes all ones, which sets the invalid bit and an impossible tag.
	assign bram_wr_data = sweep_wr ? {icache_pkg::LINE_W{1'b1}} :
		{fill_address, 1'b0, fill_data};	// tag, valid, data.

	bram #(
		.BITS        (icache_pkg::LINE_W),
		.ADDRESS_BITS(CACHE_DEPTH_BITS)
	) i_bram (
		.CLK       (CLK),
		.rd_address(request_address[CACHE_DEPTH_BITS:1]),	// index read at the edge.
		.data_out  (line_out),
		.wr_address(bram_wr_addr),
		.data_in   (bram_wr_data),
		.wr        (bram_wr)
	);

	// ==============================
	// lookup
	// ==============================
	always_ff @(posedge CLK) begin
		address_x <= request_address;	// lines up with the registered ram read.
	end

	assign tag_match  = (line_out[icache_pkg::LINE_W-1:icache_pkg::LINE_TAG_LSB] == address_x);
	assign line_valid = (line_out[icache_pkg::LINE_INV_BIT] == 1'b0);	// zero means valid.

	// outside execute the ram may hold anything, so report a miss.
	assign cache_miss   = !in_execute || !tag_match || !line_valid;
	assign address_data = line_out;

	assign miss_req     = cache_miss && in_execute;	// read port only acts in execute.
	assign miss_address = address_x;

	assign invalidation_done = (state == icache_pkg::st_invalidate_done);

	// ==============================
	// state machine
	// ==============================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= icache_pkg::st_init;
			sweep_addr <= '0;
		end else begin
			state      <= state_next;
			sweep_addr <= sweep_addr_next;
		end
	end

	always_comb begin
		state_next      = state;
		sweep_addr_next = sweep_addr;

		case (state)
			icache_pkg::st_init: begin
				state_next = icache_pkg::st_invalidate;	// one cycle only.
			end
			icache_pkg::st_invalidate: begin
				sweep_addr_next = sweep_addr + 1'b1;	// wraps to zero after the last line.
				if (&sweep_addr) begin
					state_next = icache_pkg::st_invalidate_done;
				end
			end
			icache_pkg::st_invalidate_done: begin
				state_next = icache_pkg::st_execute;
			end
			icache_pkg::st_execute: begin
				if (invalidate_cache) begin
					state_next = icache_pkg::st_invalidate;	// counter is already back at zero.
				end
			end
			default: begin
				state_next = icache_pkg::st_init;
			end
		endcase
	end

	// ==============================
	// checks
	// ==============================
	// a memory fill must never land on a line while the sweep owns the write port.
	a_no_write_clash: assert property (@(posedge CLK) disable iff (!RSTb)
		!(fill_wr && sweep_wr))
		else $error("fill and sweep write in the same cycle");

	a_done_pulse: assert property (@(posedge CLK) disable iff (!RSTb)
		invalidation_done |=> !invalidation_done)
		else $error("invalidation_done held longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/bram.sv
// Simple dual-port block RAM, one read port and one write port on the same clock.
// Read data is registered; a read and a write to one address in a cycle give the old word.
`timescale 1ns/10ps
`default_nettype none

module bram #(
	parameter int BITS         = 32,	// word width.
	parameter int ADDRESS_BITS = 8	// depth is 2**ADDRESS_BITS.
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_address,	// sampled at the edge.
	output logic [BITS-1:0]         data_out,	// valid one cycle after rd_address.
	input  logic [ADDRESS_BITS-1:0] wr_address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr	// write strobe.
);

	// ==============================
	// storage
	// ==============================
	logic [BITS-1:0] mem [2**ADDRESS_BITS];	// one word per line.

	// read first, so a same-address write is not seen until the next read.
	always_ff @(posedge CLK) begin
		data_out <= mem[rd_address];	// registered read.
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_address] <= data_in;	// one-cycle write.
		end
	end

endmodule

`default_nettype wire

//--- verilog/icache_pkg.sv
// Shared widths, line word layout and cache state encoding for the instruction fetch side.
// Taken by scoped name from the cache, the read port, the top level and the testbench.
`default_nettype none

package icache_pkg;

	// ==============================
	// address and data widths
	// ==============================
	localparam int ADDR_W = 15;	// cpu word address.
	localparam int DATA_W = 16;	// one instruction word from memory.

	// ==============================
	// line word layout
	// ==============================
	// tag in [31:17], invalid flag in [16], data in [15:0].
	localparam int LINE_W       = 32;	// full line word in the block ram.
	localparam int LINE_TAG_LSB = 17;	// lowest tag bit.
	localparam int LINE_INV_BIT = 16;	// set means the line holds nothing.

	// ==============================
	// cache state encoding
	// ==============================
	typedef enum logic [1:0] {
		st_init            = 2'd0,	// one cycle after reset.
		st_invalidate      = 2'd1,	// sweep writes one line per cycle.
		st_invalidate_done = 2'd2,	// done pulse.
		st_execute         = 2'd3	// normal lookups and fills.
	} cache_state_t;

endpackage

`default_nettype wire
